//--- src/mem_bus_settings.svh
`ifndef MEM_BUS_SETTINGS_SVH
`define MEM_BUS_SETTINGS_SVH

// Store buffer entries
`define DB_BUF_DEPTH 8

// Bus address and data widths
`define DB_ADDR_W 32
`define DB_DATA_W 32

// Byte lanes per data word
`define DB_BE_W (`DB_DATA_W / 8)

`endif

//--- src/mem_bus_pkg.sv
`default_nettype none

`include "mem_bus_settings.svh"

package mem_bus_pkg;

    // Transfer size as seen on the SRAM-like bus
    typedef enum logic [1:0] {
        SIZE_BYTE = 2'd0,
        SIZE_HALF = 2'd1,
        SIZE_WORD = 2'd2
    } bus_size_t;

    // One bus transaction whose address already carries the lane offset
    typedef struct packed {
        logic                  write;
        bus_size_t             size;
        logic [`DB_ADDR_W-1:0] addr;
        logic [`DB_DATA_W-1:0] wdata;
    } bus_req_t;

    // Access as the core presents it
    // Write data sits in the low bits
    typedef struct packed {
        logic [`DB_BE_W-1:0]   be;
        logic [`DB_ADDR_W-1:0] addr;
        logic [`DB_DATA_W-1:0] wdata;
    } cpu_req_t;

endpackage

`default_nettype wire

//--- src/lane_encoder.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_bus_settings.svh"

module lane_encoder (
    input  logic                  clk,
    input  logic                  strobe,
    input  mem_bus_pkg::cpu_req_t cpu_req,
    input  logic                  write,
    output mem_bus_pkg::bus_req_t enc_req
);

    mem_bus_pkg::bus_size_t size;
    logic [1:0]             offset;
    logic                   legal_be;

    always_comb begin
        size     = mem_bus_pkg::SIZE_WORD;
        offset   = 2'd0;
        legal_be = 1'b1;
        case (cpu_req.be)
            4'b0001: begin
                size   = mem_bus_pkg::SIZE_BYTE;
                offset = 2'd0;
            end
            4'b0010: begin
                size   = mem_bus_pkg::SIZE_BYTE;
                offset = 2'd1;
            end
            4'b0100: begin
                size   = mem_bus_pkg::SIZE_BYTE;
                offset = 2'd2;
            end
            4'b1000: begin
                size   = mem_bus_pkg::SIZE_BYTE;
                offset = 2'd3;
            end
            4'b0011: begin
                size   = mem_bus_pkg::SIZE_HALF;
                offset = 2'd0;
            end
            4'b1100: begin
                size   = mem_bus_pkg::SIZE_HALF;
                offset = 2'd2;
            end
            4'b1111: begin
                size   = mem_bus_pkg::SIZE_WORD;
                offset = 2'd0;
            end
            default: legal_be = 1'b0;
        endcase
    end

    // Top three address bits dropped since the space is mirrored
    always_comb begin
        enc_req.write = write;
        enc_req.size  = size;
        enc_req.addr  = {3'b000, cpu_req.addr[`DB_ADDR_W-4:2], offset};
        enc_req.wdata = cpu_req.wdata << {offset, 3'b000};
    end

    a_legal_be: assert property (
        @(posedge clk) strobe |-> legal_be
    ) else $error("lane_encoder: illegal byte enable %b", cpu_req.be);

endmodule

`default_nettype wire

//--- src/store_buffer.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_bus_settings.svh"

module store_buffer #(
    parameter type entry_t = logic [`DB_DATA_W-1:0],
    parameter int  DEPTH   = `DB_BUF_DEPTH
) (
    input  logic   clk,
    input  logic   rst,
    input  logic   push,
    input  entry_t din,
    input  logic   pop,
    output entry_t head,
    output logic   head_valid,
    output logic   full,
    output logic   almost_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    entry_t           mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= din;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Oldest entry is readable without a pop
    assign head        = mem[rd_ptr];
    assign head_valid  = (count != '0);
    assign full        = (count == CNT_W'(DEPTH));
    assign almost_full = (count == CNT_W'(DEPTH - 1));

    a_no_overflow: assert property (
        @(posedge clk) disable iff (rst) push |-> !full
    ) else $error("store_buffer: push while full");

    a_no_underflow: assert property (
        @(posedge clk) disable iff (rst) pop |-> head_valid
    ) else $error("store_buffer: pop while empty");

endmodule

`default_nettype wire

//--- src/bus_sequencer.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_bus_settings.svh"

module bus_sequencer (
    input  logic                   clk,
    input  logic                   rst,

    input  logic                   load,
    input  mem_bus_pkg::bus_req_t  enc_req,
    input  mem_bus_pkg::bus_req_t  head,
    input  logic                   head_valid,
    input  logic                   store,
    input  logic                   almost_full,
    input  logic                   full,
    output logic                   pop,

    output logic                   busy,
    output logic                   load_valid,
    output logic [`DB_DATA_W-1:0]  load_data,

    output logic                   data_req,
    output logic                   data_wr,
    output mem_bus_pkg::bus_size_t data_size,
    output logic [`DB_ADDR_W-1:0]  data_addr,
    output logic [`DB_DATA_W-1:0]  data_wdata,
    input  logic [`DB_DATA_W-1:0]  data_rdata,
    input  logic                   data_addr_ok,
    input  logic                   data_data_ok
);

    typedef enum logic [1:0] {
        IDLE = 2'd0,
        REQ  = 2'd1,
        WAIT = 2'd2
    } state_t;

    state_t                state;
    state_t                state_next;
    mem_bus_pkg::bus_req_t cur;
    mem_bus_pkg::bus_req_t load_req;
    logic                  load_pend;
    logic                  start_store;
    logic                  start_load;
    logic                  addr_done;
    logic                  load_done;

    // Stores always go first so a load sees every earlier store
    assign start_store = (state == IDLE) && head_valid;
    assign start_load  = (state == IDLE) && !head_valid && load_pend;
    assign addr_done   = (state == REQ) && data_addr_ok;
    assign load_done   = (state == WAIT) && data_data_ok && !cur.write;

    always_comb begin
        state_next = state;
        case (state)
            IDLE: begin
                if (start_store || start_load) begin
                    state_next = REQ;
                end
            end
            REQ: begin
                if (data_addr_ok) begin
                    state_next = WAIT;
                end
            end
            WAIT: begin
                if (data_data_ok) begin
                    state_next = IDLE;
                end
            end
            default: state_next = IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= IDLE;
            load_pend <= 1'b0;
            busy      <= 1'b0;
        end else begin
            state <= state_next;
            if (load) begin
                load_pend <= 1'b1;
            end else if (load_done) begin
                load_pend <= 1'b0;
            end
            busy <= (almost_full && store) || full || load || (load_pend && !load_done);
        end
    end

    // Pending load and the transaction on the bus
    always_ff @(posedge clk) begin
        if (load) begin
            load_req       <= enc_req;
            load_req.write <= 1'b0;
        end
        if (start_store) begin
            cur <= head;
        end else if (start_load) begin
            cur <= load_req;
        end
    end

    // Entry leaves the buffer once the bus has taken its address
    assign pop = addr_done && cur.write;

    assign data_req   = (state == REQ);
    assign data_wr    = data_req && cur.write;
    assign data_size  = cur.size;
    assign data_addr  = cur.addr;
    assign data_wdata = cur.wdata;

    assign load_valid = load_done;
    assign load_data  = data_rdata;

    a_req_stable: assert property (
        @(posedge clk) disable iff (rst)
        (data_req && !data_addr_ok) |=>
            (data_req && $stable({data_wr, data_size, data_addr, data_wdata}))
    ) else $error("bus_sequencer: request changed before addr_ok");

    a_data_ok_in_wait: assert property (
        @(posedge clk) disable iff (rst) data_data_ok |-> (state == WAIT)
    ) else $error("bus_sequencer: data_ok outside the data phase");

    a_load_not_busy: assert property (
        @(posedge clk) disable iff (rst) load |-> !busy
    ) else $error("bus_sequencer: load strobed while busy");

endmodule

`default_nettype wire

//--- src/data_bridge.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_bus_settings.svh"

module data_bridge (
    input  logic                   clk,
    input  logic                   rst,

    // Core side
    input  logic                   load,
    input  logic                   store,
    input  mem_bus_pkg::cpu_req_t  cpu_req,
    output logic                   busy,
    output logic                   load_valid,
    output logic [`DB_DATA_W-1:0]  load_data,

    // SRAM-like bus
    output logic                   data_req,
    output logic                   data_wr,
    output mem_bus_pkg::bus_size_t data_size,
    output logic [`DB_ADDR_W-1:0]  data_addr,
    output logic [`DB_DATA_W-1:0]  data_wdata,
    input  logic [`DB_DATA_W-1:0]  data_rdata,
    input  logic                   data_addr_ok,
    input  logic                   data_data_ok
);

    mem_bus_pkg::bus_req_t enc_req;
    mem_bus_pkg::bus_req_t head;
    logic                  head_valid;
    logic                  full;
    logic                  almost_full;
    logic                  pop;

    lane_encoder u_lane_encoder (
        .clk     (clk),
        .strobe  (load | store),
        .cpu_req (cpu_req),
        .write   (store),
        .enc_req (enc_req)
    );

    store_buffer #(
        .entry_t (mem_bus_pkg::bus_req_t),
        .DEPTH   (`DB_BUF_DEPTH)
    ) u_store_buffer (
        .clk         (clk),
        .rst         (rst),
        .push        (store),
        .din         (enc_req),
        .pop         (pop),
        .head        (head),
        .head_valid  (head_valid),
        .full        (full),
        .almost_full (almost_full)
    );

    bus_sequencer u_bus_sequencer (
        .clk          (clk),
        .rst          (rst),
        .load         (load),
        .enc_req      (enc_req),
        .head         (head),
        .head_valid   (head_valid),
        .store        (store),
        .almost_full  (almost_full),
        .full         (full),
        .pop          (pop),
        .busy         (busy),
        .load_valid   (load_valid),
        .load_data    (load_data),
        .data_req     (data_req),
        .data_wr      (data_wr),
        .data_size    (data_size),
        .data_addr    (data_addr),
        .data_wdata   (data_wdata),
        .data_rdata   (data_rdata),
        .data_addr_ok (data_addr_ok),
        .data_data_ok (data_data_ok)
    );

endmodule

`default_nettype wire

//--- bench/sram_like_model.sv
`timescale 1ns/100ps
`default_nettype none

module sram_like_model (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   data_req,
    input  logic                   data_wr,
    input  mem_bus_pkg::bus_size_t data_size,
    input  logic [31:0]            data_addr,
    input  logic [31:0]            data_wdata,
    output logic [31:0]            data_rdata,
    output logic                   data_addr_ok,
    output logic                   data_data_ok,
    output logic                   proto_err
);

    logic [31:0]           mem [1024];
    mem_bus_pkg::bus_req_t req;
    logic [3:0]            lanes;
    logic [1:0]            phase;
    logic [1:0]            delay;

    initial begin
        data_rdata   = '0;
        data_addr_ok = 1'b0;
        data_data_ok = 1'b0;
        proto_err    = 1'b0;
        for (int i = 0; i < 1024; i++) begin
            mem[i] = 32'hc300_0000 ^ {6'd0, 10'(i), 6'd0, 10'(i)};
        end
    end

    task automatic report_violation(input string what);
        $display("sram_like_model: %s at %0t", what, $time);
        proto_err <= 1'b1;
    endtask

    // Phase 0 idle, 1 address phase, 2 data phase
    always @(posedge clk) begin
        if (rst) begin
            phase        <= 2'd0;
            delay        <= 2'd0;
            data_addr_ok <= 1'b0;
            data_data_ok <= 1'b0;
            data_rdata   <= '0;
            proto_err    <= 1'b0;
        end else begin
            data_addr_ok <= 1'b0;
            data_data_ok <= 1'b0;
            case (phase)
                2'd0: begin
                    if (data_req) begin
                        req   <= {data_wr, data_size, data_addr, data_wdata};
                        lanes <= (data_size == mem_bus_pkg::SIZE_WORD) ? 4'b1111 :
                                 (data_size == mem_bus_pkg::SIZE_HALF ? 4'b0011 : 4'b0001)
                                 << data_addr[1:0];
                        delay <= 2'($urandom_range(3, 0));
                        phase <= 2'd1;
                        assert (data_addr[31:29] == 3'b000
                                && (data_size != mem_bus_pkg::SIZE_HALF || !data_addr[0])
                                && (data_size != mem_bus_pkg::SIZE_WORD
                                    || data_addr[1:0] == 2'b00))
                            else report_violation("misaligned request or upper address bits set");
                    end
                end
                2'd1: begin
                    assert (data_req && {data_wr, data_size, data_addr, data_wdata} == req)
                        else report_violation("request dropped or changed before addr_ok");
                    if (data_addr_ok) begin
                        delay <= 2'($urandom_range(3, 0));
                        phase <= 2'd2;
                    end else if (delay == 2'd0) begin
                        data_addr_ok <= 1'b1;
                    end else begin
                        delay <= delay - 2'd1;
                    end
                end
                default: begin
                    assert (!data_req)
                        else report_violation("new request while a transfer is in flight");
                    if (data_data_ok) begin
                        phase <= 2'd0;
                    end else if (delay == 2'd0) begin
                        for (int k = 0; k < 4; k++) begin
                            if (req.write && lanes[k]) begin
                                mem[req.addr[11:2]][8*k +: 8] = req.wdata[8*k +: 8];
                            end
                        end
                        data_rdata   <= mem[req.addr[11:2]];
                        data_data_ok <= 1'b1;
                    end else begin
                        delay <= delay - 2'd1;
                    end
                end
            endcase
        end
    end

endmodule

`default_nettype wire

//--- bench/tb_data_bridge.sv
`timescale 1ns/100ps
`default_nettype none

`include "mem_bus_settings.svh"

module tb_data_bridge;

    localparam int TIMEOUT = 2000;

    logic                   clk;
    logic                   rst;
    logic                   load;
    logic                   store;
    mem_bus_pkg::cpu_req_t  cpu_req;
    logic                   busy;
    logic                   load_valid;
    logic [31:0]            load_data;
    logic                   data_req;
    logic                   data_wr;
    mem_bus_pkg::bus_size_t data_size;
    logic [31:0]            data_addr;
    logic [31:0]            data_wdata;
    logic [31:0]            data_rdata;
    logic                   data_addr_ok;
    logic                   data_data_ok;
    logic                   proto_err;

    logic [31:0] ref_mem [1024];
    logic [31:0] exp_q [$];
    logic [31:0] addr_q [$];
    logic [3:0]  legal_be [7] = '{4'b0001, 4'b0010, 4'b0100, 4'b1000,
                                  4'b0011, 4'b1100, 4'b1111};
    int          loads_sent;
    int          loads_done;
    int          stall_cycles;

    data_bridge u_data_bridge (.*);
    sram_like_model u_sram_like_model (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic abort_run(input string msg);
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1);
    endtask

    // Same power-up contents as the memory model
    function automatic logic [31:0] fill_word(input logic [9:0] idx);
        return 32'hc300_0000 ^ {6'd0, idx, 6'd0, idx};
    endfunction

    // Core data sits in the low bits and fills the enabled lanes from the lowest one up
    function automatic logic [31:0] ref_load(input logic [9:0] idx, input logic write,
                                             input logic [3:0] be, input logic [31:0] wdata);
        int          lo;
        logic [31:0] word;
        word = ref_mem[idx];
        if (write) begin
            lo = 0;
            while (!be[lo] && lo < 3) begin
                lo++;
            end
            for (int k = 0; k < 4; k++) begin
                if (be[k]) begin
                    word[8*k +: 8] = wdata[8*(k-lo) +: 8];
                end
            end
            ref_mem[idx] = word;
        end
        return word;
    endfunction

    task automatic wait_not_busy();
        int n;
        n = 0;
        while (busy) begin
            @(negedge clk);
            n++;
            stall_cycles++;
            assert (n < TIMEOUT) else abort_run("timeout waiting for busy to drop");
        end
    endtask

    task automatic store_access(input logic [31:0] addr, input logic [3:0] be,
                                input logic [31:0] wdata);
        wait_not_busy();
        store         = 1'b1;
        cpu_req.be    = be;
        cpu_req.addr  = addr;
        cpu_req.wdata = wdata;
        void'(ref_load(addr[11:2], 1'b1, be, wdata));
        @(negedge clk);
        store = 1'b0;
    endtask

    task automatic load_access(input logic [31:0] addr, input logic [3:0] be);
        wait_not_busy();
        load          = 1'b1;
        cpu_req.be    = be;
        cpu_req.addr  = addr;
        cpu_req.wdata = $urandom;
        exp_q.push_back(ref_load(addr[11:2], 1'b0, be, '0));
        addr_q.push_back(addr);
        loads_sent++;
        @(negedge clk);
        load = 1'b0;
    endtask

    // Each load_valid retires the oldest expected word
    always @(negedge clk) begin
        if (!rst && load_valid) begin
            assert (exp_q.size() > 0) else abort_run("load_valid with no load outstanding");
            assert (load_data === exp_q[0])
                else abort_run($sformatf("Fail at %0t: load from %h returned %h, expected %h",
                                         $time, addr_q[0], load_data, exp_q[0]));
            void'(exp_q.pop_front());
            void'(addr_q.pop_front());
            loads_done++;
        end
        assert (!proto_err) else abort_run("memory model saw a bus protocol violation");
    end

    initial begin
        logic [31:0] a;
        int          n;
        void'($urandom(42));
        rst          = 1'b1;
        load         = 1'b0;
        store        = 1'b0;
        cpu_req      = '0;
        loads_sent   = 0;
        loads_done   = 0;
        stall_cycles = 0;
        for (int i = 0; i < 1024; i++) begin
            ref_mem[i] = fill_word(10'(i));
        end
        repeat (5) @(negedge clk);
        rst = 1'b0;
        repeat (10) begin
            @(negedge clk);
            assert (!busy && !load_valid) else abort_run("busy or load_valid high after reset");
        end

        store_access(32'h0000_0010, 4'b1111, 32'hdead_beef);
        load_access(32'h0000_0010, 4'b1111);

        // Lanes of one word from separate narrow stores
        store_access(32'h0000_0020, 4'b0001, 32'h5a5a_5a11);
        store_access(32'h0000_0020, 4'b0010, 32'h0000_0022);
        store_access(32'h0000_0020, 4'b1100, 32'hffff_4433);
        load_access(32'h0000_0020, 4'b1111);

        // Newest store wins and the upper bits mirror onto the same word
        store_access(32'he000_0030, 4'b1111, 32'h1111_1111);
        store_access(32'h0000_0030, 4'b1111, 32'h2222_2222);
        store_access(32'h2000_0030, 4'b0011, 32'h0000_3333);
        load_access(32'h0000_0030, 4'b0001);

        wait_not_busy();
        n = stall_cycles;
        for (int i = 0; i < `DB_BUF_DEPTH + 4; i++) begin
            store_access(32'h100 + 32'(4 * i), 4'b1111, $urandom);
        end
        assert (stall_cycles > n) else abort_run("busy never rose during the store burst");
        wait_not_busy();
        for (int i = 0; i < `DB_BUF_DEPTH + 4; i++) begin
            load_access(32'h100 + 32'(4 * i), 4'b1111);
        end

        for (int i = 0; i < 500; i++) begin
            a       = $urandom;
            a[11:2] = 10'($urandom_range(15, 0));
            a[1:0]  = 2'b00;
            if ($urandom_range(1, 0) == 0) begin
                store_access(a, legal_be[$urandom_range(6, 0)], $urandom);
            end else begin
                load_access(a, legal_be[$urandom_range(6, 0)]);
            end
        end

        n = 0;
        while (loads_done < loads_sent) begin
            @(negedge clk);
            n++;
            assert (n < TIMEOUT) else abort_run("timeout waiting for the last load to return");
        end
        repeat (20) @(negedge clk);
        $display("NO ERRORS");
        $finish;
    end

endmodule

`default_nettype wire

//--- filelist.f
+incdir+src
src/mem_bus_pkg.sv
src/lane_encoder.sv
src/store_buffer.sv
src/bus_sequencer.sv
src/data_bridge.sv
bench/sram_like_model.sv
bench/tb_data_bridge.sv

//--- run.sh
#!/bin/sh
# Build and run the data_bridge testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_data_bridge \
    -f filelist.f \
    -o tb_data_bridge

./obj_dir/tb_data_bridge
